// File: stq_pkg.sv
package stq_pkg;

    // queue geometry.
    localparam int STQ_ENTRIES = 8;

    // free entries left when dispatch is told to stall.
    localparam int STQ_STALL_MARGIN = 2;

    // entry index.
    typedef logic [2:0] stq_id_t;

    // one bit per entry.
    typedef logic [STQ_ENTRIES-1:0] stq_vec_t;

    typedef logic [5:0] rob_id_t;

    typedef logic [31:0] st_addr_t;

    typedef logic [31:0] st_data_t;

    // byte, half or word.
    typedef logic [1:0] st_size_t;

    // per-entry lifecycle.
    typedef enum logic [1:0] {
        ST_FREE,
        ST_WAIT_ADDR,
        ST_READY
    } stq_state_t;

endpackage

// File: stq_entries.sv
`timescale 1ns/100ps

module stq_entries (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic                disp_valid,
    input  stq_pkg::rob_id_t    disp_robid,
    input  stq_pkg::st_size_t   disp_size,
    input  logic                iss_valid,
    input  stq_pkg::stq_id_t    iss_stqid,
    input  stq_pkg::st_addr_t   iss_addr,
    input  stq_pkg::st_data_t   iss_data,
    input  stq_pkg::stq_vec_t   gnt_vec,
    input  stq_pkg::st_addr_t   lookup_addr,
    output stq_pkg::stq_id_t    stqid_alloc,
    output stq_pkg::stq_vec_t   alloc_vec,
    output stq_pkg::stq_vec_t   e_valid,
    output stq_pkg::stq_vec_t   e_ready,
    output stq_pkg::rob_id_t    e_robid [stq_pkg::STQ_ENTRIES],
    output stq_pkg::st_addr_t   e_addr  [stq_pkg::STQ_ENTRIES],
    output stq_pkg::st_data_t   e_data  [stq_pkg::STQ_ENTRIES],
    output stq_pkg::st_size_t   e_size  [stq_pkg::STQ_ENTRIES],
    output stq_pkg::stq_vec_t   lookup_match
);

    import stq_pkg::*;

    stq_state_t e_state [STQ_ENTRIES];

    stq_id_t    free_idx;
    stq_vec_t   free_onehot;
    logic       alloc_ok;
    logic       iss_ok;
    stq_vec_t   iss_vec;

    // state decode.
    always_comb begin
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            e_valid[e] = (e_state[e] != ST_FREE);
            e_ready[e] = (e_state[e] == ST_READY);
        end
    end

    // lowest free entry wins.
    always_comb begin
        free_idx = '0;
        for (int e = STQ_ENTRIES - 1; e >= 0; e--) begin
            if (!e_valid[e]) begin
                free_idx = stq_id_t'(e);
            end
        end
    end

    assign free_onehot = stq_vec_t'(1) << free_idx;
    assign alloc_ok    = disp_valid & ~(&e_valid) & ~nuke;
    assign alloc_vec   = alloc_ok ? free_onehot : '0;
    assign stqid_alloc = free_idx;

    // issue only lands on an entry still waiting for its address.
    assign iss_ok  = iss_valid & ~nuke & (e_state[iss_stqid] == ST_WAIT_ADDR);
    assign iss_vec = iss_ok ? (stq_vec_t'(1) << iss_stqid) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < STQ_ENTRIES; e++) begin
                e_state[e] <= ST_FREE;
            end
        end else begin
            for (int e = 0; e < STQ_ENTRIES; e++) begin
                if (nuke) begin
                    e_state[e] <= ST_FREE;
                end else if (alloc_vec[e]) begin
                    e_state[e] <= ST_WAIT_ADDR;
                end else if (iss_vec[e]) begin
                    e_state[e] <= ST_READY;
                end else if (gnt_vec[e]) begin
                    e_state[e] <= ST_FREE;
                end
            end
        end
    end

    // payload, written on allocation and on issue.
    always_ff @(posedge clk) begin
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (alloc_vec[e]) begin
                e_robid[e] <= disp_robid;
                e_size[e]  <= disp_size;
            end
            if (iss_vec[e]) begin
                e_addr[e] <= iss_addr;
                e_data[e] <= iss_data;
            end
        end
    end

    // word-granular address compare.
    always_comb begin
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            lookup_match[e] = e_ready[e] & (e_addr[e][31:2] == lookup_addr[31:2]);
        end
    end

endmodule

// File: stq_age_matrix.sv
`timescale 1ns/100ps

module stq_age_matrix (
    input  logic                clk,
    input  logic                rst_n,
    input  stq_pkg::stq_vec_t   alloc_vec,
    output stq_pkg::stq_vec_t   elders [stq_pkg::STQ_ENTRIES]
);

    import stq_pkg::*;

    // entries allocated at least once since reset.
    stq_vec_t seen;
    logic     any_alloc;

    assign any_alloc = |alloc_vec;

    // row r holds the entries older than r.
    // stale bits of retired entries get masked by the arbiter.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen <= '0;
            for (int r = 0; r < STQ_ENTRIES; r++) begin
                elders[r] <= '0;
            end
        end else if (any_alloc) begin
            seen <= seen | alloc_vec;
            for (int r = 0; r < STQ_ENTRIES; r++) begin
                if (alloc_vec[r]) begin
                    // everyone already here is older.
                    elders[r] <= seen & ~alloc_vec;
                end else begin
                    // the new entry is younger than this one.
                    elders[r] <= elders[r] & ~alloc_vec;
                end
            end
        end
    end

endmodule

// File: stq_pipe_arb.sv
`timescale 1ns/100ps

module stq_pipe_arb (
    input  stq_pkg::stq_vec_t   e_ready,
    input  stq_pkg::stq_vec_t   elders  [stq_pkg::STQ_ENTRIES],
    input  stq_pkg::rob_id_t    e_robid [stq_pkg::STQ_ENTRIES],
    input  stq_pkg::st_addr_t   e_addr  [stq_pkg::STQ_ENTRIES],
    input  stq_pkg::st_data_t   e_data  [stq_pkg::STQ_ENTRIES],
    input  stq_pkg::st_size_t   e_size  [stq_pkg::STQ_ENTRIES],
    input  logic                pipe_gnt,
    output logic                pipe_req,
    output stq_pkg::stq_id_t    pipe_stqid,
    output stq_pkg::rob_id_t    pipe_robid,
    output stq_pkg::st_addr_t   pipe_addr,
    output stq_pkg::st_data_t   pipe_data,
    output stq_pkg::st_size_t   pipe_size,
    output stq_pkg::stq_vec_t   gnt_vec
);

    import stq_pkg::*;

    stq_vec_t sel;

    // oldest requester has no ready elder.
    always_comb begin
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            sel[e] = e_ready[e] & ~(|(elders[e] & e_ready));
        end
    end

    assign pipe_req = |e_ready;
    assign gnt_vec  = pipe_gnt ? sel : '0;

    always_comb begin
        pipe_stqid = '0;
        pipe_robid = '0;
        pipe_addr  = '0;
        pipe_data  = '0;
        pipe_size  = '0;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (sel[e]) begin
                pipe_stqid = stq_id_t'(e);
                pipe_robid = e_robid[e];
                pipe_addr  = e_addr[e];
                pipe_data  = e_data[e];
                pipe_size  = e_size[e];
            end
        end
    end

endmodule

// File: stq_top.sv
`timescale 1ns/100ps

module stq_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic                disp_valid,
    input  stq_pkg::rob_id_t    disp_robid,
    input  stq_pkg::st_size_t   disp_size,
    input  logic                iss_valid,
    input  stq_pkg::stq_id_t    iss_stqid,
    input  stq_pkg::st_addr_t   iss_addr,
    input  stq_pkg::st_data_t   iss_data,
    input  logic                pipe_gnt,
    input  stq_pkg::st_addr_t   lookup_addr,
    output stq_pkg::stq_id_t    stqid_alloc,
    output logic                pipe_req,
    output stq_pkg::stq_id_t    pipe_stqid,
    output stq_pkg::rob_id_t    pipe_robid,
    output stq_pkg::st_addr_t   pipe_addr,
    output stq_pkg::st_data_t   pipe_data,
    output stq_pkg::st_size_t   pipe_size,
    output stq_pkg::stq_vec_t   lookup_match,
    output logic                idle,
    output logic                full,
    output logic                stall
);

    import stq_pkg::*;

    stq_vec_t alloc_vec;
    stq_vec_t e_valid;
    stq_vec_t e_ready;
    stq_vec_t gnt_vec;
    stq_vec_t elders  [STQ_ENTRIES];
    rob_id_t  e_robid [STQ_ENTRIES];
    st_addr_t e_addr  [STQ_ENTRIES];
    st_data_t e_data  [STQ_ENTRIES];
    st_size_t e_size  [STQ_ENTRIES];

    stq_entries u_entries (
        .clk          (clk),
        .rst_n        (rst_n),
        .nuke         (nuke),
        .disp_valid   (disp_valid),
        .disp_robid   (disp_robid),
        .disp_size    (disp_size),
        .iss_valid    (iss_valid),
        .iss_stqid    (iss_stqid),
        .iss_addr     (iss_addr),
        .iss_data     (iss_data),
        .gnt_vec      (gnt_vec),
        .lookup_addr  (lookup_addr),
        .stqid_alloc  (stqid_alloc),
        .alloc_vec    (alloc_vec),
        .e_valid      (e_valid),
        .e_ready      (e_ready),
        .e_robid      (e_robid),
        .e_addr       (e_addr),
        .e_data       (e_data),
        .e_size       (e_size),
        .lookup_match (lookup_match)
    );

    stq_age_matrix u_age (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc_vec (alloc_vec),
        .elders    (elders)
    );

    stq_pipe_arb u_arb (
        .e_ready    (e_ready),
        .elders     (elders),
        .e_robid    (e_robid),
        .e_addr     (e_addr),
        .e_data     (e_data),
        .e_size     (e_size),
        .pipe_gnt   (pipe_gnt),
        .pipe_req   (pipe_req),
        .pipe_stqid (pipe_stqid),
        .pipe_robid (pipe_robid),
        .pipe_addr  (pipe_addr),
        .pipe_data  (pipe_data),
        .pipe_size  (pipe_size),
        .gnt_vec    (gnt_vec)
    );

    // occupancy status.
    assign idle  = ~(|e_valid);
    assign full  = &e_valid;
    assign stall = $countones(e_valid) >= (STQ_ENTRIES - STQ_STALL_MARGIN);

endmodule

// File: stq_sva.sv
`timescale 1ns/100ps

module stq_sva (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic                pipe_gnt,
    input  logic                pipe_req,
    input  stq_pkg::stq_id_t    pipe_stqid,
    input  stq_pkg::st_addr_t   pipe_addr,
    input  stq_pkg::st_data_t   pipe_data,
    input  stq_pkg::stq_vec_t   alloc_vec,
    input  logic                idle,
    input  logic                full
);

    // failed assertion count.
    int fail_count = 0;

    a_req_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !pipe_req)
        else begin
            fail_count++;
            $error("pipe_req high in the first cycle after reset");
        end

    a_full_idle: assert property (@(posedge clk) disable iff (!rst_n) !(full && idle))
        else begin
            fail_count++;
            $error("full and idle both high");
        end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> alloc_vec == '0)
        else begin
            fail_count++;
            $error("entry allocated while the queue is full");
        end

    // an older entry may take over, otherwise the payload holds.
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pipe_req && !pipe_gnt && !nuke |=> pipe_req &&
            (pipe_stqid != $past(pipe_stqid) || ($stable(pipe_addr) && $stable(pipe_data))))
        else begin
            fail_count++;
            $error("pipe request changed under back-pressure");
        end

endmodule

bind stq_top stq_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .nuke       (nuke),
    .pipe_gnt   (pipe_gnt),
    .pipe_req   (pipe_req),
    .pipe_stqid (pipe_stqid),
    .pipe_addr  (pipe_addr),
    .pipe_data  (pipe_data),
    .alloc_vec  (alloc_vec),
    .idle       (idle),
    .full       (full)
);

// File: tb_stq_top.sv
`timescale 1ns/100ps

module tb_stq_top;

    import stq_pkg::*;

    localparam int RAND_CYCLES = 300;
    // directed phases add about sixty operations to the random run.
    localparam int NUM_OPS = RAND_CYCLES + 60;

    logic       clk;
    logic       rst_n;
    logic       nuke;
    logic       disp_valid;
    rob_id_t    disp_robid;
    st_size_t   disp_size;
    logic       iss_valid;
    stq_id_t    iss_stqid;
    st_addr_t   iss_addr;
    st_data_t   iss_data;
    logic       pipe_gnt;
    st_addr_t   lookup_addr;
    stq_id_t    stqid_alloc;
    logic       pipe_req;
    stq_id_t    pipe_stqid;
    rob_id_t    pipe_robid;
    st_addr_t   pipe_addr;
    st_data_t   pipe_data;
    st_size_t   pipe_size;
    stq_vec_t   lookup_match;
    logic       idle;
    logic       full;
    logic       stall;

    // reference copy of the queue.
    stq_state_t m_state [STQ_ENTRIES];
    rob_id_t    m_robid [STQ_ENTRIES];
    st_size_t   m_size  [STQ_ENTRIES];
    st_addr_t   m_addr  [STQ_ENTRIES];
    st_data_t   m_data  [STQ_ENTRIES];
    int         m_seq   [STQ_ENTRIES];
    int         next_seq;

    integer     seed;
    int         errors;
    int         checks;

    stq_top uut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_id(input string name, input stq_id_t got, input stq_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_vec(input string name, input stq_vec_t got, input stq_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input st_addr_t got, input st_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input st_data_t got, input st_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rob(input string name, input rob_id_t got, input rob_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_size(input string name, input st_size_t got, input st_size_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // oldest ready entry by allocation order, -1 if none.
    function automatic int oldest_ready();
        int best;
        best = -1;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (m_state[e] == ST_READY && (best < 0 || m_seq[e] < m_seq[best])) begin
                best = e;
            end
        end
        return best;
    endfunction

    function automatic int lowest_free();
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (m_state[e] == ST_FREE) begin
                return e;
            end
        end
        return -1;
    endfunction

    function automatic int valid_count();
        int cnt;
        cnt = 0;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (m_state[e] != ST_FREE) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    function automatic stq_vec_t word_match(input st_addr_t a);
        stq_vec_t v;
        v = '0;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            v[e] = (m_state[e] == ST_READY) && (m_addr[e][31:2] == a[31:2]);
        end
        return v;
    endfunction

    // random waiting entry, -1 if none.
    function automatic int pick_waiting();
        int start;
        int e;
        start = $random(seed) & 7;
        for (int k = 0; k < STQ_ENTRIES; k++) begin
            e = (start + k) % STQ_ENTRIES;
            if (m_state[e] == ST_WAIT_ADDR) begin
                return e;
            end
        end
        return -1;
    endfunction

    // small address window so that lookups hit often.
    function automatic st_addr_t rand_addr();
        return 32'h8000_0000 | (st_addr_t'($random(seed)) & 32'h0000_003f);
    endfunction

    task automatic compare_outputs();
        int old;
        int cnt;
        old = oldest_ready();
        cnt = valid_count();
        check_bit("idle", idle, cnt == 0);
        check_bit("full", full, cnt == STQ_ENTRIES);
        check_bit("stall", stall, cnt >= STQ_ENTRIES - STQ_STALL_MARGIN);
        check_bit("pipe_req", pipe_req, old >= 0);
        check_vec("lookup_match", lookup_match, word_match(lookup_addr));
        // alloc id only defined while a slot is free.
        if (cnt < STQ_ENTRIES) begin
            check_id("stqid_alloc", stqid_alloc, stq_id_t'(lowest_free()));
        end
        if (old >= 0) begin
            check_id("pipe_stqid", pipe_stqid, stq_id_t'(old));
            check_rob("pipe_robid", pipe_robid, m_robid[old]);
            check_size("pipe_size", pipe_size, m_size[old]);
            check_addr("pipe_addr", pipe_addr, m_addr[old]);
            check_data("pipe_data", pipe_data, m_data[old]);
        end
    endtask

    // advance the model by one clock edge.
    task automatic step_model();
        int old;
        int fr;
        old = oldest_ready();
        fr = lowest_free();
        if (nuke) begin
            for (int e = 0; e < STQ_ENTRIES; e++) begin
                m_state[e] = ST_FREE;
            end
        end else begin
            if (iss_valid && m_state[iss_stqid] == ST_WAIT_ADDR) begin
                m_state[iss_stqid] = ST_READY;
                m_addr[iss_stqid] = iss_addr;
                m_data[iss_stqid] = iss_data;
            end
            if (disp_valid && fr >= 0) begin
                m_state[fr] = ST_WAIT_ADDR;
                m_robid[fr] = disp_robid;
                m_size[fr] = disp_size;
                m_seq[fr] = next_seq;
                next_seq++;
            end
            if (pipe_gnt && old >= 0) begin
                m_state[old] = ST_FREE;
            end
        end
    endtask

    // outputs settle well before the rising edge.
    always begin
        @(negedge clk);
        #4;
        if (rst_n) begin
            compare_outputs();
            step_model();
        end
    end

    task automatic clear_strobes();
        nuke = 1'b0;
        disp_valid = 1'b0;
        iss_valid = 1'b0;
        pipe_gnt = 1'b0;
    endtask

    task automatic drive_lookup();
        int e;
        e = $random(seed) & 7;
        // half the probes land near a stored address.
        if (($random(seed) & 1) != 0) begin
            lookup_addr = m_addr[e] ^ st_addr_t'($random(seed) & 3);
        end else begin
            lookup_addr = rand_addr();
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_strobes();
        drive_lookup();
    endtask

    task automatic drive_dispatch();
        disp_valid = 1'b1;
        disp_robid = rob_id_t'($random(seed));
        disp_size = st_size_t'(($random(seed) & 32'h7fff_ffff) % 3);
    endtask

    task automatic drive_issue(input int e);
        iss_valid = 1'b1;
        iss_stqid = stq_id_t'(e);
        iss_addr = rand_addr();
        iss_data = st_data_t'($random(seed));
    endtask

    // issue whatever waits and grant until the model is empty.
    task automatic drain_queue();
        int w;
        while (valid_count() != 0) begin
            next_cycle();
            pipe_gnt = 1'b1;
            w = pick_waiting();
            if (w >= 0) begin
                drive_issue(w);
            end
        end
        next_cycle();
    endtask

    initial begin
        int order [STQ_ENTRIES];
        int w;
        order = '{5, 2, 7, 0, 3, 6, 1, 4};
        seed = 32'h6b0e_fce2;
        errors = 0;
        checks = 0;
        next_seq = 0;
        rst_n = 1'b0;
        clear_strobes();
        disp_robid = '0;
        disp_size = '0;
        iss_stqid = '0;
        iss_addr = '0;
        iss_data = '0;
        lookup_addr = '0;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            m_state[e] = ST_FREE;
            m_robid[e] = '0;
            m_size[e] = '0;
            m_addr[e] = '0;
            m_data[e] = '0;
            m_seq[e] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) next_cycle();
        // fill lowest-first, the last dispatch hits a full queue.
        repeat (STQ_ENTRIES + 1) begin
            next_cycle();
            drive_dispatch();
        end
        // out-of-order issue with grants held off.
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            next_cycle();
            drive_issue(order[i]);
        end
        repeat (3) next_cycle();
        drain_queue();
        repeat (RAND_CYCLES) begin
            next_cycle();
            if (($random(seed) & 1) != 0) begin
                drive_dispatch();
            end
            w = pick_waiting();
            if (w < 0) begin
                w = $random(seed) & 7;
            end
            if (($random(seed) & 1) != 0) begin
                drive_issue(w);
            end
            pipe_gnt = ($random(seed) & 3) != 0;
        end
        drain_queue();
        repeat (4) begin
            next_cycle();
            drive_dispatch();
        end
        repeat (2) begin
            next_cycle();
            w = pick_waiting();
            if (w >= 0) begin
                drive_issue(w);
            end
        end
        // nuke wins over a same-cycle dispatch.
        next_cycle();
        nuke = 1'b1;
        drive_dispatch();
        repeat (3) next_cycle();
        @(posedge clk);
        #1;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_sva.fail_count);
        if (errors == 0 && uut.u_sva.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 20 + 200) @(posedge clk);
        $display("watchdog expired before the test sequence completed");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: list.f
stq_pkg.sv
stq_entries.sv
stq_age_matrix.sv
stq_pipe_arb.sv
stq_top.sv
stq_sva.sv
tb_stq_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_stq_top -f list.f -o tb_stq_top \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_stq_top > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "simulator returned an error status" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
